//--- hdl/rx_buffer_pkg.sv
// shared definitions for the two-channel receive buffer
//   character, FIFO and pointer widths
//   received character, fill level and host word structs
//   capture FSM state codes
//   gray code conversion over pointer width
`default_nettype none

package rx_buffer_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int char_width = 8;   // framed data bits
  localparam int fifo_depth = 16;  // words per channel
  localparam int addr_width = 4;   // memory index
  localparam int ptr_width  = 5;   // index plus wrap bit

  // capture FSM encoding
  localparam logic [1:0] cap_idle      = 2'b00;
  localparam logic [1:0] cap_acked     = 2'b01;
  localparam logic [1:0] cap_wait_drop = 2'b10;  // request seen, FIFO full

  // ------------------------------
  // structs
  // ------------------------------
  typedef struct packed {
    logic [char_width-1:0] data;
    logic                  parity_err;
    logic                  framing_err;
  } rx_char_t;

  // read-domain flags of one FIFO
  typedef struct packed {
    logic empty;
    logic q_full;   // 4 or more
    logic h_full;   // 8 or more
    logic a_full;   // 14 or more
  } fifo_level_t;

  typedef struct packed {
    logic     channel;  // source channel tag
    rx_char_t char;
  } host_word_t;

  // ------------------------------
  // gray code
  // ------------------------------
  function automatic logic [ptr_width-1:0] bin2gray(input logic [ptr_width-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [ptr_width-1:0] gray2bin(input logic [ptr_width-1:0] g);
    logic [ptr_width-1:0] b;
    b[ptr_width-1] = g[ptr_width-1];  // msb passes straight
    for (int i = ptr_width - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

endpackage

`default_nettype wire

//--- hdl/rx_char_capture.sv
// write-side capture stage for one channel
//   four-phase slave on the producer link
//   one FIFO write per handshake, ack held back while full
`default_nettype none

module rx_char_capture (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  logic                    rx_req,
  input  rx_buffer_pkg::rx_char_t rx_char,
  output logic                    rx_ack,
  input  logic                    full,
  output logic                    wr,
  output rx_buffer_pkg::rx_char_t wr_char
);
  import rx_buffer_pkg::*;

  logic [1:0] state;
  logic [1:0] state_nxt;

  // ------------------------------
  // write strobe
  // ------------------------------
  // fresh request plus room, fires on the edge that raises ack
  assign wr = rx_req & ~full & (state != cap_acked);

  // producer holds the character until ack, no need to latch it
  assign wr_char = rx_char;

  assign rx_ack = (state == cap_acked);  // straight from state reg

  // ------------------------------
  // handshake FSM
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      cap_idle: begin
        if (rx_req) begin
          state_nxt = full ? cap_wait_drop : cap_acked;  // stall or take it
        end
      end
      cap_wait_drop: begin
        if (!rx_req) begin
          state_nxt = cap_idle;  // producer withdrew
        end
        else if (!full) begin
          state_nxt = cap_acked;  // slot freed, write now
        end
      end
      cap_acked: begin
        if (!rx_req) begin
          state_nxt = cap_idle;  // ack drops with req
        end
      end
      default: begin
        state_nxt = cap_idle;
      end
    endcase
  end

  always_ff @(posedge clk_wr or posedge rst) begin
    if (rst) begin
      state <= cap_idle;
    end
    else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

//--- hdl/async_fifo16.sv
// 16-word dual-clock FIFO
//   memory written on clk_wr, head word read combinationally
//   binary and gray pointers, two-flop synchronizers both ways
//   soft reset from clk_rd carried to clk_wr by a req/ack pair
//   empty, quarter, half and almost-full flags on the read side
`default_nettype none

module async_fifo16 #(
  parameter int DATA_WIDTH = 10  // stored word width
) (
  input  logic                       clk_wr,
  input  logic                       clk_rd,
  input  logic                       rst,
  input  logic                       srst,   // clk_rd domain
  input  logic                       wr,
  input  logic [DATA_WIDTH-1:0]      d,
  input  logic                       rd,
  output logic [DATA_WIDTH-1:0]      q,
  output rx_buffer_pkg::fifo_level_t level,  // clk_rd domain
  output logic                       full    // clk_wr domain
);
  import rx_buffer_pkg::*;

  logic [DATA_WIDTH-1:0] mem [fifo_depth];

  // write side
  logic [ptr_width-1:0] wr_bin;
  logic [ptr_width-1:0] wr_bin_nxt;
  logic [ptr_width-1:0] wr_gray;
  logic [ptr_width-1:0] rd_gray_w1;   // read ptr, first sync stage
  logic [ptr_width-1:0] rd_gray_w2;   // read ptr seen by clk_wr
  logic                 ifull;
  logic                 wr_en;
  logic                 flush_w1;
  logic                 flush_w;      // flush request seen by clk_wr

  // read side
  logic [ptr_width-1:0] rd_bin;
  logic [ptr_width-1:0] rd_bin_nxt;
  logic [ptr_width-1:0] rd_gray;
  logic [ptr_width-1:0] wr_gray_r1;
  logic [ptr_width-1:0] wr_gray_r2;   // write ptr seen by clk_rd
  logic [ptr_width-1:0] fill;         // words held, as seen by clk_rd
  logic                 iempty;
  logic                 empty_i;
  logic                 rd_en;
  logic                 flush_req;    // soft reset in progress
  logic                 ack_r1;
  logic                 flush_ack;    // write side has cleared

  // ------------------------------
  // memory
  // ------------------------------
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_bin[addr_width-1:0]] <= d;
    end
  end

  assign q = mem[rd_bin[addr_width-1:0]];  // head word, no read latency

  // ------------------------------
  // write pointer
  // ------------------------------
  // full when read ptr is one lap behind: top two gray bits inverted
  assign ifull = (wr_gray == {~rd_gray_w2[ptr_width-1 -: 2], rd_gray_w2[ptr_width-3:0]});

  // hold the writer off during a flush as well
  assign full = ifull | flush_w;

  assign wr_en      = wr & ~full;  // write while full is dropped
  assign wr_bin_nxt = wr_bin + ptr_width'(1);

  always_ff @(posedge clk_wr or posedge rst) begin
    if (rst) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end
    else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      if (flush_w) begin
        wr_bin  <= '0;  // soft reset reached this side
        wr_gray <= '0;
      end
      else if (wr_en) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= bin2gray(wr_bin_nxt);
      end
    end
  end

  // ------------------------------
  // read pointer
  // ------------------------------
  assign iempty  = (rd_gray == wr_gray_r2);
  assign empty_i = iempty | flush_req | flush_ack;  // stale words hidden until flush ends

  assign rd_en      = rd & ~empty_i;  // pop of empty FIFO is ignored
  assign rd_bin_nxt = rd_bin + ptr_width'(1);

  always_ff @(posedge clk_rd or posedge rst) begin
    if (rst) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end
    else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      if (srst || flush_req) begin
        rd_bin  <= '0;  // cleared the cycle after srst is seen
        rd_gray <= '0;
      end
      else if (rd_en) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= bin2gray(rd_bin_nxt);
      end
    end
  end

  // ------------------------------
  // level flags
  // ------------------------------
  // count from synced write ptr, mod 32 so wrap is harmless
  assign fill = gray2bin(wr_gray_r2) - rd_bin;

  assign level.empty  = empty_i;
  assign level.q_full = ~empty_i & (fill >= ptr_width'(fifo_depth / 4));
  assign level.h_full = ~empty_i & (fill >= ptr_width'(fifo_depth / 2));
  assign level.a_full = ~empty_i & (fill >= ptr_width'(fifo_depth - 2));

  // ------------------------------
  // soft reset crossing
  // ------------------------------
  // clk_rd raises flush_req, clk_wr echoes it back once its ptr is clear
  always_ff @(posedge clk_rd or posedge rst) begin
    if (rst) begin
      flush_req <= 1'b0;
      ack_r1    <= 1'b0;
      flush_ack <= 1'b0;
    end
    else begin
      ack_r1    <= flush_w;
      flush_ack <= ack_r1;
      if (srst) begin
        flush_req <= 1'b1;
      end
      else if (flush_ack) begin
        flush_req <= 1'b0;  // write side done
      end
    end
  end

  always_ff @(posedge clk_wr or posedge rst) begin
    if (rst) begin
      flush_w1 <= 1'b0;
      flush_w  <= 1'b0;
    end
    else begin
      flush_w1 <= flush_req;
      flush_w  <= flush_w1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rx_channel_merge.sv
// read-side merge of the two channel FIFOs
//   channel choice by half-full flag, else turn taking
//   one-cycle pop of the chosen FIFO
//   four-phase responder on the host link
//   registered interrupt from the almost-full flags
`default_nettype none

module rx_channel_merge (
  input  logic                       clk_rd,
  input  logic                       rst,
  input  rx_buffer_pkg::fifo_level_t level0,
  input  rx_buffer_pkg::fifo_level_t level1,
  input  rx_buffer_pkg::rx_char_t    q0,
  input  rx_buffer_pkg::rx_char_t    q1,
  output logic                       rd0,
  output logic                       rd1,
  input  logic                       host_req,
  output logic                       host_ack,
  output rx_buffer_pkg::host_word_t  host_word,
  output logic                       irq
);
  import rx_buffer_pkg::*;

  logic     avail0;     // channel 0 has a word
  logic     avail1;
  logic     sel;        // chosen channel
  logic     take;       // load, pop and ack on this edge
  logic     last_sel;   // channel served last
  rx_char_t sel_char;

  // ------------------------------
  // channel choice
  // ------------------------------
  assign avail0 = ~level0.empty;
  assign avail1 = ~level1.empty;

  always_comb begin
    if (level0.h_full ^ level1.h_full) begin
      sel = level1.h_full;  // the one filling up goes first
    end
    else if (avail0 && avail1) begin
      sel = ~last_sel;      // take turns
    end
    else begin
      sel = avail1;         // whichever has data, 0 if none
    end
  end

  assign sel_char = sel ? q1 : q0;

  // ------------------------------
  // pop
  // ------------------------------
  // new request with ack low and something to give
  assign take = host_req & ~host_ack & (avail0 | avail1);

  assign rd0 = take & ~sel;
  assign rd1 = take & sel;

  // ------------------------------
  // host handshake
  // ------------------------------
  always_ff @(posedge clk_rd or posedge rst) begin
    if (rst) begin
      host_ack <= 1'b0;
      last_sel <= 1'b0;  // so channel 1 wins the first tie
    end
    else begin
      if (take) begin
        host_ack <= 1'b1;
        last_sel <= sel;
      end
      else if (!host_req) begin
        host_ack <= 1'b0;  // four-phase return to zero
      end
    end
  end

  // word register, only loaded with ack low so it holds while ack is up
  always_ff @(posedge clk_rd) begin
    if (take) begin
      host_word.channel <= sel;
      host_word.char    <= sel_char;
    end
  end

  // ------------------------------
  // interrupt
  // ------------------------------
  always_ff @(posedge clk_rd or posedge rst) begin
    if (rst) begin
      irq <= 1'b0;
    end
    else begin
      irq <= level0.a_full | level1.a_full;  // either channel nearly full
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_rx_buffer_top.sv
// two-channel receive buffer top level
//   per channel a capture stage feeding a dual-clock FIFO
//   merge stage serving the host in the clk_rd domain
`default_nettype none

module uart_rx_buffer_top (
  input  logic                       clk_wr,
  input  logic                       clk_rd,
  input  logic                       rst,
  input  logic                       srst,      // clk_rd domain
  input  logic                       rx_req0,
  input  logic                       rx_req1,
  input  rx_buffer_pkg::rx_char_t    rx_char0,
  input  rx_buffer_pkg::rx_char_t    rx_char1,
  output logic                       rx_ack0,
  output logic                       rx_ack1,
  input  logic                       host_req,
  output logic                       host_ack,
  output rx_buffer_pkg::host_word_t  host_word,
  output rx_buffer_pkg::fifo_level_t level0,
  output rx_buffer_pkg::fifo_level_t level1,
  output logic                       full0,
  output logic                       full1,
  output logic                       irq
);
  import rx_buffer_pkg::*;

  // capture to FIFO
  logic     wr0;
  logic     wr1;
  rx_char_t wr_char0;
  rx_char_t wr_char1;

  // FIFO to merge
  logic     rd0;
  logic     rd1;
  rx_char_t q0;
  rx_char_t q1;

  // ------------------------------
  // channel 0
  // ------------------------------
  rx_char_capture u_cap0 (
    .clk_wr  (clk_wr),
    .rst     (rst),
    .rx_req  (rx_req0),
    .rx_char (rx_char0),
    .rx_ack  (rx_ack0),
    .full    (full0),
    .wr      (wr0),
    .wr_char (wr_char0)
  );

  async_fifo16 #(
    .DATA_WIDTH ($bits(rx_char_t))
  ) u_fifo0 (
    .clk_wr (clk_wr),
    .clk_rd (clk_rd),
    .rst    (rst),
    .srst   (srst),
    .wr     (wr0),
    .d      (wr_char0),
    .rd     (rd0),
    .q      (q0),
    .level  (level0),
    .full   (full0)
  );

  // ------------------------------
  // channel 1
  // ------------------------------
  rx_char_capture u_cap1 (
    .clk_wr  (clk_wr),
    .rst     (rst),
    .rx_req  (rx_req1),
    .rx_char (rx_char1),
    .rx_ack  (rx_ack1),
    .full    (full1),
    .wr      (wr1),
    .wr_char (wr_char1)
  );

  async_fifo16 #(
    .DATA_WIDTH ($bits(rx_char_t))
  ) u_fifo1 (
    .clk_wr (clk_wr),
    .clk_rd (clk_rd),
    .rst    (rst),
    .srst   (srst),   // one soft reset flushes both
    .wr     (wr1),
    .d      (wr_char1),
    .rd     (rd1),
    .q      (q1),
    .level  (level1),
    .full   (full1)
  );

  // ------------------------------
  // host side
  // ------------------------------
  rx_channel_merge u_merge (
    .clk_rd    (clk_rd),
    .rst       (rst),
    .level0    (level0),
    .level1    (level1),
    .q0        (q0),
    .q1        (q1),
    .rd0       (rd0),
    .rd1       (rd1),
    .host_req  (host_req),
    .host_ack  (host_ack),
    .host_word (host_word),
    .irq       (irq)
  );

endmodule

`default_nettype wire

//--- verification/uart_rx_buffer_properties.sv
// protocol assertions for the receive buffer top level
//   producer acks rise only on a request and with room
//   host word held while host_ack is up
//   host_ack never rises with both FIFOs empty
`default_nettype none

module uart_rx_buffer_properties (
  input logic                       clk_wr,
  input logic                       clk_rd,
  input logic                       rst,
  input logic                       rx_req0,
  input logic                       rx_req1,
  input logic                       rx_ack0,
  input logic                       rx_ack1,
  input logic                       full0,
  input logic                       full1,
  input logic                       host_req,
  input logic                       host_ack,
  input rx_buffer_pkg::host_word_t  host_word,
  input rx_buffer_pkg::fifo_level_t level0,
  input rx_buffer_pkg::fifo_level_t level1
);
  timeunit 1ns;
  timeprecision 1ps;
  import rx_buffer_pkg::*;

  int fail_count = 0;  // read by the testbench at the end

  // ------------------------------
  // producer links, clk_wr
  // ------------------------------
  ack0_needs_req: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_ack0) |-> $past(rx_req0))
    else begin fail_count++; $error("rx_ack0 rose with rx_req0 low"); end

  ack1_needs_req: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_ack1) |-> $past(rx_req1))
    else begin fail_count++; $error("rx_ack1 rose with rx_req1 low"); end

  // ack means a write happened, so never while full
  ack0_needs_room: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_ack0) |-> !$past(full0))
    else begin fail_count++; $error("rx_ack0 rose while full0 was high"); end

  ack1_needs_room: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_ack1) |-> !$past(full1))
    else begin fail_count++; $error("rx_ack1 rose while full1 was high"); end

  // ------------------------------
  // host link, clk_rd
  // ------------------------------
  word_held: assert property (@(posedge clk_rd) disable iff (rst)
    host_ack && $past(host_ack) |-> $stable(host_word))
    else begin fail_count++; $error("host_word changed while host_ack was high"); end

  ack_needs_data: assert property (@(posedge clk_rd) disable iff (rst)
    $rose(host_ack) |-> !$past(level0.empty && level1.empty))
    else begin fail_count++; $error("host_ack rose with both FIFOs empty"); end

endmodule

bind uart_rx_buffer_top uart_rx_buffer_properties u_props (.*);

`default_nettype wire

//--- verification/tb_uart_rx_buffer.sv
// testbench for the two-channel receive buffer
//   clocks, reset, producer and host drivers
//   per-channel reference queues, data and channel checks
//   level flag, back-pressure and soft reset sequences
`default_nettype none

module tb_uart_rx_buffer;
  timeunit 1ns;
  timeprecision 1ps;
  import rx_buffer_pkg::*;

  localparam int wait_limit   = 200;  // cycles per wait loop
  localparam int stall_cycles = 24;   // window with no ack expected
  localparam int cross_cycles = 5;    // pointer sync plus irq register

  logic        clk_wr;
  logic        clk_rd;
  logic        rst;
  logic        srst;
  logic [1:0]  rx_req;
  rx_char_t    rx_char [2];
  logic [1:0]  rx_ack;
  logic        host_req;
  logic        host_ack;
  host_word_t  host_word;
  fifo_level_t level0;
  fifo_level_t level1;
  logic [1:0]  full;
  logic        irq;

  rx_char_t ref_q [2][$];   // chars acked, per channel
  int       seed    = 79606;
  int       checks  = 0;
  int       errors  = 0;
  logic     last_ch = 1'b0; // channel 0 counts as served after reset

  uart_rx_buffer_top uut (
    .clk_wr (clk_wr), .clk_rd (clk_rd), .rst (rst), .srst (srst),
    .rx_req0 (rx_req[0]), .rx_req1 (rx_req[1]),
    .rx_char0 (rx_char[0]), .rx_char1 (rx_char[1]),
    .rx_ack0 (rx_ack[0]), .rx_ack1 (rx_ack[1]),
    .host_req (host_req), .host_ack (host_ack), .host_word (host_word),
    .level0 (level0), .level1 (level1),
    .full0 (full[0]), .full1 (full[1]), .irq (irq)
  );

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  initial begin
    clk_rd = 1'b0;
    forever #17 clk_rd = ~clk_rd;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic rx_char_t next_char();
    logic [31:0] r;
    r = $random(seed);
    return r[$bits(rx_char_t)-1:0];
  endfunction

  // channel the merge stage should take, from the words still pending
  function automatic logic expected_channel();
    logic half0;
    logic half1;
    half0 = (ref_q[0].size() >= fifo_depth / 2);
    half1 = (ref_q[1].size() >= fifo_depth / 2);
    if (half0 != half1) return half1;
    if (ref_q[0].size() > 0 && ref_q[1].size() > 0) return ~last_ch;  // turn taking
    return ref_q[1].size() > 0;
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, uut.u_props.fail_count);
  endtask

  task automatic timeout_abort(input string what);
    errors++;
    $display("timeout: %s", what);
    print_counts();
    $display("Test failed");
    $finish;
  endtask

  task automatic let_pointers_cross();
    repeat (cross_cycles) @(posedge clk_rd);  // 2 to 3 cycles sync, then margin
  endtask

  task automatic wait_ack(input int ch, input logic val);
    int n;
    n = 0;
    do begin
      @(posedge clk_wr);
      n++;
    end while (rx_ack[ch] !== val && n < wait_limit);
    if (rx_ack[ch] !== val) timeout_abort($sformatf("rx_ack%0d never reached %b", ch, val));
  endtask

  // one full four-phase producer transfer
  task automatic write_char(input int ch);
    rx_char_t c;
    c = next_char();
    @(posedge clk_wr);
    rx_char[ch] <= c;
    rx_req[ch]  <= 1'b1;
    wait_ack(ch, 1'b1);
    ref_q[ch].push_back(c);
    rx_req[ch] <= 1'b0;
    wait_ack(ch, 1'b0);
  endtask

  task automatic read_host(input string name);
    host_word_t w;
    rx_char_t   exp;
    logic       exp_ch;
    int         n;
    exp_ch = 1'b0;
    n = 0;
    @(posedge clk_rd);
    host_req <= 1'b1;
    do begin
      @(posedge clk_rd);
      if (!host_ack) exp_ch = expected_channel();  // pending words at this edge
      n++;
    end while (!host_ack && n < wait_limit);
    if (!host_ack) timeout_abort("host_ack never rose");
    w = host_word;
    host_req <= 1'b0;
    check_value({name, " channel"}, exp_ch, w.channel);
    if (ref_q[w.channel].size() == 0) begin
      errors++;
      $display("%s: word from channel %0d with nothing pending", name, w.channel);
    end
    else begin
      exp = ref_q[w.channel].pop_front();
      check_value({name, " char"}, exp, w.char);
    end
    last_ch = w.channel;
    n = 0;
    do begin
      @(posedge clk_rd);
      n++;
    end while (host_ack && n < wait_limit);
    if (host_ack) timeout_abort("host_ack never fell");
  endtask

  task automatic drain_all(input string name);
    while (ref_q[0].size() + ref_q[1].size() > 0) read_host(name);
  endtask

  // one more request against a full FIFO, released by a single host read
  task automatic stall_then_release(input int ch, input string name);
    rx_char_t held;
    held = next_char();
    @(posedge clk_wr);
    rx_char[ch] <= held;
    rx_req[ch]  <= 1'b1;
    repeat (stall_cycles) begin
      @(posedge clk_wr);
      check_value({name, " ack held off"}, 16'h0, rx_ack[ch]);
    end
    read_host(name);  // frees one slot
    wait_ack(ch, 1'b1);
    ref_q[ch].push_back(held);
    rx_req[ch] <= 1'b0;
    wait_ack(ch, 1'b0);
  endtask

  task automatic apply_soft_reset();
    int n;
    @(posedge clk_rd);
    srst <= 1'b1;
    @(posedge clk_rd);
    srst <= 1'b0;
    ref_q[0].delete();  // FIFO contents are gone
    ref_q[1].delete();
    n = 0;
    do begin
      @(posedge clk_wr);
      n++;
    end while (!full[0] && n < wait_limit);
    if (!full[0]) timeout_abort("soft reset never reached the write side");
    n = 0;
    do begin
      @(posedge clk_wr);
      n++;
    end while (full != 2'b00 && n < wait_limit);
    if (full != 2'b00) timeout_abort("full stayed high after soft reset");
    let_pointers_cross();  // flush ack travels back to clk_rd
  endtask

  // ------------------------------
  // sequence
  // ------------------------------
  initial begin
    fifo_level_t exp_lvl;
    rst        = 1'b1;
    srst       = 1'b0;
    rx_req     = 2'b00;
    rx_char[0] = '0;
    rx_char[1] = '0;
    host_req   = 1'b0;
    repeat (8) @(posedge clk_wr);
    rst <= 1'b0;
    let_pointers_cross();
    check_value("reset level0", 16'h8, level0);  // only empty set
    check_value("reset level1", 16'h8, level1);
    check_value("reset outputs", 16'h0, {rx_ack, host_ack, irq, full});

    // host request parked on empty FIFOs until a word lands
    fork
      read_host("empty wait");
      begin
        repeat (stall_cycles) @(posedge clk_wr);
        write_char(0);
      end
    join

    // integrity and order, short bursts on both channels
    repeat (3) write_char(0);
    repeat (3) write_char(1);
    let_pointers_cross();
    drain_all("order");

    // level flags on channel 1, one word at a time
    for (int n = 1; n <= fifo_depth; n++) begin
      write_char(1);
      let_pointers_cross();
      exp_lvl.empty  = 1'b0;
      exp_lvl.q_full = (n >= 4);
      exp_lvl.h_full = (n >= 8);
      exp_lvl.a_full = (n >= 14);
      check_value($sformatf("level n=%0d", n), exp_lvl, level1);
      // channel 0 drained, so only channel 1 feeds irq
      check_value($sformatf("irq n=%0d", n), exp_lvl.a_full, irq);
    end
    check_value("full1 at 16", 16'h1, full[1]);
    stall_then_release(1, "level back-pressure");
    drain_all("level drain");

    // back-pressure on channel 0
    repeat (fifo_depth) write_char(0);
    check_value("full0 at 16", 16'h1, full[0]);
    stall_then_release(0, "back-pressure");
    drain_all("back-pressure");

    // selection: channel 1 half full first, then turn taking
    repeat (2) write_char(0);
    repeat (9) write_char(1);
    let_pointers_cross();
    drain_all("select");

    // soft reset with words in both FIFOs
    repeat (3) write_char(0);
    repeat (5) write_char(1);
    let_pointers_cross();
    apply_soft_reset();
    check_value("srst level0", 16'h8, level0);
    check_value("srst level1", 16'h8, level1);
    check_value("srst full", 16'h0, full);
    repeat (2) write_char(0);
    repeat (2) write_char(1);
    let_pointers_cross();
    drain_all("after srst");
    check_value("final empty", 16'h3, {level0.empty, level1.empty});

    print_counts();
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("Test passed");
    end
    else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/rx_buffer_pkg.sv
hdl/rx_char_capture.sv
hdl/async_fifo16.sv
hdl/rx_channel_merge.sv
hdl/uart_rx_buffer_top.sv
verification/uart_rx_buffer_properties.sv
verification/tb_uart_rx_buffer.sv
